//--- design/enc_macros.svh
// encoder interface constants: channel count, widths, reset value, address map, filter length
`ifndef ENC_MACROS_SVH
`define ENC_MACROS_SVH

// ----------------------------------------
// sizing
// ----------------------------------------
`define ENC_NUM_CHANNELS 4          // channels numbered 1 to ENC_NUM_CHANNELS
`define ENC_CNT_W        24         // position count width
`define ENC_PERD_W       32         // period timer width
`define ENC_REG_W        32         // host read bus width

// value the counters and preloads start from
`define ENC_MIDRANGE     24'h800000

// consecutive equal samples needed before a filtered line moves
`define ENC_DEB_CYCLES   8

// ----------------------------------------
// write address map
// ----------------------------------------
`define ENC_ADDR_MAIN    4'h0       // waddr[15:12], main register space
`define ENC_OFF_LOAD     4'h4       // waddr[3:0], preload register offset

`endif

//--- design/enc_pkg.sv
// shared encoder types: position count, counter result, period value, channel index
`include "enc_macros.svh"

package enc_pkg;

   // raw position count, wraps modulo 2^ENC_CNT_W
   typedef logic [`ENC_CNT_W-1:0] enc_count_t;

   // counter result as seen on the read bus, overflow in the msb
   typedef struct packed {
      logic       ovf;    // sticky, set on any wrap
      enc_count_t count;
   } enc_quad_t;

   // clock cycle count, saturates at all ones
   typedef logic [`ENC_PERD_W-1:0] enc_period_t;

   // channel number as carried in waddr[7:4] and reg_raddr_chan
   typedef logic [3:0] enc_chan_t;

endpackage

//--- design/enc_chan_if.sv
// per-channel link carrying preload and load to a channel and its measurements back
interface enc_chan_if import enc_pkg::*; ();

   // register control to channel
   enc_count_t  preload;   // preload value, valid with load
   logic        load;      // one-cycle strobe after an accepted write

   // channel to register control
   enc_quad_t   quad;      // position count with overflow
   enc_period_t perd;      // full cycle, sum of the last four quarters
   enc_period_t qtr1;      // latest quarter period
   enc_period_t qtr5;      // quarter period four edges back
   enc_period_t run;       // cycles since the last edge

   modport ctrl (
      output preload,
      output load,
      input  quad,
      input  perd,
      input  qtr1,
      input  qtr5,
      input  run
   );

   modport chan (
      input  preload,
      input  load,
      output quad,
      output perd,
      output qtr1,
      output qtr5,
      output run
   );

endinterface

//--- design/enc_debounce.sv
// encoder line filter: two-flop synchronizer followed by a stability counter
`include "enc_macros.svh"

module enc_debounce (
   input  logic sysclk,   // system clock
   input  logic rst,      // sync reset, active high
   input  logic raw,      // asynchronous pad level
   output logic filt      // filtered level
);

   localparam int CNT_W = $clog2(`ENC_DEB_CYCLES + 1);

   logic             sync1, sync2;   // synchronizer stages
   logic [CNT_W-1:0] stable_cnt;     // samples already seen at the new level
   logic             filt_q;

   // ----------------------------------------
   // synchronizer
   // ----------------------------------------
   always_ff @(posedge sysclk) begin
      if (rst) begin
         sync1 <= 1'b0;   // line assumed low
         sync2 <= 1'b0;
      end else begin
         sync1 <= raw;
         sync2 <= sync1;
      end
   end

   // ----------------------------------------
   // stability filter
   // ----------------------------------------
   // output flips on the ENC_DEB_CYCLES-th consecutive differing sample,
   // any sample back at the old level starts the count over
   always_ff @(posedge sysclk) begin
      if (rst) begin
         stable_cnt <= '0;
         filt_q     <= 1'b0;
      end else if (sync2 == filt_q) begin
         stable_cnt <= '0;                                  // glitch ended or no change
      end else if (stable_cnt == CNT_W'(`ENC_DEB_CYCLES - 1)) begin
         filt_q     <= sync2;                               // held long enough
         stable_cnt <= '0;
      end else begin
         stable_cnt <= stable_cnt + 1'b1;
      end
   end

   assign filt = filt_q;

endmodule

//--- design/enc_quad_counter.sv
// 4x quadrature decoder with preloadable position count, sticky overflow and direction
`include "enc_macros.svh"

module enc_quad_counter import enc_pkg::*; (
   input  logic       sysclk,    // system clock
   input  logic       rst,       // sync reset, active high
   input  logic       a,         // filtered A line
   input  logic       b,         // filtered B line
   input  logic       load,      // preload strobe, wins over an edge
   input  enc_count_t preload,   // value taken on load
   output enc_quad_t  quad,      // overflow and count
   output logic       dir,       // direction of the last edge, 1 = up
   output logic       step       // high in the cycle an edge is seen
);

   logic      a_q, b_q;   // previous line levels
   logic      up;         // decoded direction of the current edge
   enc_quad_t quad_q;
   logic      dir_q;

   // any change on either line is one quarter step
   assign step = (a ^ a_q) | (b ^ b_q);

   // A leading B counts up: new A differs from old B
   assign up = a ^ b_q;

   always_ff @(posedge sysclk) begin
      if (rst) begin
         a_q    <= 1'b0;
         b_q    <= 1'b0;
         quad_q <= '{ovf: 1'b0, count: `ENC_MIDRANGE};
         dir_q  <= 1'b0;
      end else begin
         a_q <= a;
         b_q <= b;
         if (load) begin
            quad_q.count <= preload;
            quad_q.ovf   <= 1'b0;   // a fresh preload clears the wrap flag
         end else if (step) begin
            dir_q <= up;
            if (up) begin
               quad_q.count <= quad_q.count + 1'b1;
               quad_q.ovf   <= quad_q.ovf | (&quad_q.count);   // wrap to zero
            end else begin
               quad_q.count <= quad_q.count - 1'b1;
               quad_q.ovf   <= quad_q.ovf | ~(|quad_q.count);  // wrap to all ones
            end
         end
      end
   end

   assign quad = quad_q;
   assign dir  = dir_q;

endmodule

//--- design/enc_period_meter.sv
// edge timing: latest and old quarter periods, full cycle and running count
`include "enc_macros.svh"

module enc_period_meter import enc_pkg::*; (
   input  logic        sysclk,   // system clock
   input  logic        rst,      // sync reset, active high
   input  logic        step,     // one cycle per filtered edge
   output enc_period_t perd,     // sum of the last four quarters
   output enc_period_t qtr1,     // latest quarter
   output enc_period_t qtr5,     // quarter four edges before the latest
   output enc_period_t run       // cycles since the last edge
);

   enc_period_t               tmr;        // free-running since the last edge
   logic                      armed;      // first edge seen, timer has a reference
   logic                      tmr_max;
   enc_period_t               qtr_new;    // quarter ending at this edge
   enc_period_t               hist [0:3]; // hist[0] newest
   enc_period_t               old_q;      // entry pushed out of the history
   logic [`ENC_PERD_W+1:0]    sum;        // two guard bits for four terms

   assign tmr_max = &tmr;

   // edge falls on the cycle after the last timer value, so add one
   assign qtr_new = tmr_max ? tmr : tmr + 1'b1;

   // ----------------------------------------
   // timer and quarter history
   // ----------------------------------------
   always_ff @(posedge sysclk) begin
      if (rst) begin
         tmr     <= '0;
         armed   <= 1'b0;
         hist[0] <= '0;
         hist[1] <= '0;
         hist[2] <= '0;
         hist[3] <= '0;
         old_q   <= '0;
      end else if (step) begin
         tmr   <= '0;             // restart at every edge
         armed <= 1'b1;
         if (armed) begin         // first edge after reset only sets the reference
            hist[0] <= qtr_new;
            hist[1] <= hist[0];
            hist[2] <= hist[1];
            hist[3] <= hist[2];
            old_q   <= hist[3];
         end
      end else if (armed && !tmr_max) begin
         tmr <= tmr + 1'b1;       // stops at all ones
      end
   end

   // ----------------------------------------
   // outputs
   // ----------------------------------------
   assign sum = {2'b00, hist[0]} + {2'b00, hist[1]}
              + {2'b00, hist[2]} + {2'b00, hist[3]};

   // saturate the full cycle when the guard bits are used
   assign perd = (|sum[`ENC_PERD_W+1:`ENC_PERD_W]) ? '1 : sum[`ENC_PERD_W-1:0];
   assign qtr1 = hist[0];
   assign qtr5 = old_q;
   assign run  = tmr;

endmodule

//--- design/enc_channel.sv
// one encoder channel: line filters, position counter and period meter
module enc_channel (
   input  logic       sysclk,   // system clock
   input  logic       rst,      // sync reset, active high
   input  logic       enc_a,    // raw A pad
   input  logic       enc_b,    // raw B pad
   enc_chan_if.chan   bus       // preload in, measurements out
);

   logic a_filt;   // filtered A
   logic b_filt;   // filtered B
   logic step;     // edge seen by the counter

   // ----------------------------------------
   // line filters
   // ----------------------------------------
   enc_debounce filt_a_i (
      .sysclk (sysclk),
      .rst    (rst),
      .raw    (enc_a),
      .filt   (a_filt)
   );

   enc_debounce filt_b_i (
      .sysclk (sysclk),
      .rst    (rst),
      .raw    (enc_b),
      .filt   (b_filt)
   );

   // position count, dir stays local since periods are unsigned
   enc_quad_counter quad_i (
      .sysclk  (sysclk),
      .rst     (rst),
      .a       (a_filt),
      .b       (b_filt),
      .load    (bus.load),
      .preload (bus.preload),
      .quad    (bus.quad),
      .dir     (),
      .step    (step)
   );

   // edge-to-edge timing
   enc_period_meter perd_i (
      .sysclk (sysclk),
      .rst    (rst),
      .step   (step),
      .perd   (bus.perd),
      .qtr1   (bus.qtr1),
      .qtr5   (bus.qtr5),
      .run    (bus.run)
   );

endmodule

//--- design/enc_reg_ctrl.sv
// encoder register block: preload writes, load strobes and read-side channel select
`include "enc_macros.svh"

module enc_reg_ctrl import enc_pkg::*; (
   input  logic                  sysclk,           // system clock
   input  logic                  rst,              // sync reset, active high
   input  logic [15:0]           reg_waddr,        // host write address
   input  logic [31:0]           reg_wdata,        // host write data
   input  logic                  reg_wen,          // host write enable
   input  enc_chan_t             reg_raddr_chan,   // channel to read
   enc_chan_if.ctrl              chan [1:`ENC_NUM_CHANNELS],
   output logic [`ENC_REG_W-1:0] reg_preload,
   output logic [`ENC_REG_W-1:0] reg_quad_data,
   output logic [`ENC_REG_W-1:0] reg_perd_data,
   output logic [`ENC_REG_W-1:0] reg_qtr1_data,
   output logic [`ENC_REG_W-1:0] reg_qtr5_data,
   output logic [`ENC_REG_W-1:0] reg_run_data
);

   enc_count_t                  preload_q [1:`ENC_NUM_CHANNELS];
   logic [1:`ENC_NUM_CHANNELS]  load_q;          // one strobe per channel
   enc_chan_t                   wr_chan;
   logic                        wr_hit;          // accepted preload write
   logic                        rd_ok;           // read channel exists
   enc_quad_t                   quad_rd [1:`ENC_NUM_CHANNELS];
   enc_period_t                 perd_rd [1:`ENC_NUM_CHANNELS];
   enc_period_t                 qtr1_rd [1:`ENC_NUM_CHANNELS];
   enc_period_t                 qtr5_rd [1:`ENC_NUM_CHANNELS];
   enc_period_t                 run_rd  [1:`ENC_NUM_CHANNELS];

   // ----------------------------------------
   // write decode
   // ----------------------------------------
   assign wr_chan = reg_waddr[7:4];
   assign wr_hit  = reg_wen
                  && (reg_waddr[15:12] == `ENC_ADDR_MAIN)
                  && (reg_waddr[3:0] == `ENC_OFF_LOAD)
                  && (wr_chan != '0)
                  && (wr_chan <= enc_chan_t'(`ENC_NUM_CHANNELS));

   always_ff @(posedge sysclk) begin
      if (rst) begin
         load_q <= '0;
         for (int i = 1; i <= `ENC_NUM_CHANNELS; i++) begin
            preload_q[i] <= `ENC_MIDRANGE;
         end
      end else begin
         load_q <= '0;                                      // strobe lasts one cycle
         if (wr_hit) begin
            preload_q[wr_chan] <= reg_wdata[`ENC_CNT_W-1:0];
            load_q[wr_chan]    <= 1'b1;
         end
      end
   end

   // interface arrays need constant indices, so flatten per channel
   for (genvar i = 1; i <= `ENC_NUM_CHANNELS; i++) begin : g_chan
      assign chan[i].preload = preload_q[i];
      assign chan[i].load    = load_q[i];
      assign quad_rd[i]      = chan[i].quad;
      assign perd_rd[i]      = chan[i].perd;
      assign qtr1_rd[i]      = chan[i].qtr1;
      assign qtr5_rd[i]      = chan[i].qtr5;
      assign run_rd[i]       = chan[i].run;
   end

   // ----------------------------------------
   // read select
   // ----------------------------------------
   assign rd_ok = (reg_raddr_chan != '0)
                && (reg_raddr_chan <= enc_chan_t'(`ENC_NUM_CHANNELS));   // else reads zero

   assign reg_preload   = rd_ok ? `ENC_REG_W'(preload_q[reg_raddr_chan]) : '0;
   assign reg_quad_data = rd_ok ? `ENC_REG_W'(quad_rd[reg_raddr_chan])   : '0;   // ovf at bit 24
   assign reg_perd_data = rd_ok ? perd_rd[reg_raddr_chan] : '0;
   assign reg_qtr1_data = rd_ok ? qtr1_rd[reg_raddr_chan] : '0;
   assign reg_qtr5_data = rd_ok ? qtr5_rd[reg_raddr_chan] : '0;
   assign reg_run_data  = rd_ok ? run_rd[reg_raddr_chan]  : '0;

endmodule

//--- design/enc_top.sv
// quadrature encoder subsystem top: per-channel decoders behind a host register block
`include "enc_macros.svh"

module enc_top (
   input  logic                        sysclk,           // system clock
   input  logic                        rst,              // sync reset, active high
   input  logic [1:`ENC_NUM_CHANNELS]  enc_a,            // raw A pads
   input  logic [1:`ENC_NUM_CHANNELS]  enc_b,            // raw B pads
   input  logic [3:0]                  reg_raddr_chan,   // read channel select
   input  logic [15:0]                 reg_waddr,        // write address
   input  logic [31:0]                 reg_wdata,        // write data
   input  logic                        reg_wen,          // write enable
   output logic [31:0]                 reg_preload,      // selected preload
   output logic [31:0]                 reg_quad_data,    // count, overflow at bit 24
   output logic [31:0]                 reg_perd_data,    // full cycle period
   output logic [31:0]                 reg_qtr1_data,    // latest quarter period
   output logic [31:0]                 reg_qtr5_data,    // older quarter period
   output logic [31:0]                 reg_run_data      // running period
);

   // one link per channel
   enc_chan_if chan_bus [1:`ENC_NUM_CHANNELS] ();

   // ----------------------------------------
   // encoder channels
   // ----------------------------------------
   for (genvar i = 1; i <= `ENC_NUM_CHANNELS; i++) begin : g_enc
      enc_channel chan_i (
         .sysclk (sysclk),
         .rst    (rst),
         .enc_a  (enc_a[i]),
         .enc_b  (enc_b[i]),
         .bus    (chan_bus[i].chan)
      );
   end

   // host side, write decode and read select
   enc_reg_ctrl ctrl_i (
      .sysclk         (sysclk),
      .rst            (rst),
      .reg_waddr      (reg_waddr),
      .reg_wdata      (reg_wdata),
      .reg_wen        (reg_wen),
      .reg_raddr_chan (reg_raddr_chan),
      .chan           (chan_bus),
      .reg_preload    (reg_preload),
      .reg_quad_data  (reg_quad_data),
      .reg_perd_data  (reg_perd_data),
      .reg_qtr1_data  (reg_qtr1_data),
      .reg_qtr5_data  (reg_qtr5_data),
      .reg_run_data   (reg_run_data)
   );

endmodule

//--- verif/enc_tb.sv
// encoder subsystem testbench with a gray edge generator, a count and period model and assertions
`include "enc_macros.svh"

module enc_tb;

   localparam int NCH     = `ENC_NUM_CHANNELS;
   localparam int LAT     = `ENC_DEB_CYCLES + 3;   // pad edge to count and timer update
   localparam int MAX_CYC = 20000;                 // well above the total stimulus length

   logic          sysclk;
   logic          rst;
   logic [1:NCH]  enc_a;
   logic [1:NCH]  enc_b;
   logic [3:0]    reg_raddr_chan;
   logic [15:0]   reg_waddr;
   logic [31:0]   reg_wdata;
   logic          reg_wen;
   logic [31:0]   reg_preload;
   logic [31:0]   reg_quad_data;
   logic [31:0]   reg_perd_data;
   logic [31:0]   reg_qtr1_data;
   logic [31:0]   reg_qtr5_data;
   logic [31:0]   reg_run_data;

   // reference model state
   logic [23:0]   exp_pre [1:NCH];
   logic [23:0]   exp_cnt [1:NCH];
   logic          exp_ovf [1:NCH];
   int            phase   [1:NCH];   // gray cycle position 0 to 3
   int            qtr_hist [$];      // gaps of the tracked channel with the newest first
   int            last_gap;          // gap still running on the tracked channel
   int            pch;               // tracked channel or 0 for none
   int            seed = 32'hcad8;
   int            cycles;

   enc_top dut_i (.*);

   initial begin
      sysclk = 1'b0;
      forever #10 sysclk = ~sysclk;
   end

   // run limit
   initial begin
      cycles = 0;
      while (cycles < MAX_CYC) begin
         @(posedge sysclk);
         cycles++;
      end
      $display("run timed out after %0d cycles", cycles);
      $display("CHECKS FAILED");
      $fatal(1, "timeout");
   end

   task automatic fail_now(input string msg);
      $display("FAIL t=%0t %s", $time, msg);
      $display("CHECKS FAILED");
      $fatal(1, "check failed");
   endtask

   // ----------------------------------------
   // unmapped channels read back zero on every bus
   // ----------------------------------------
   assert property (@(posedge sysclk) disable iff (rst)
      (reg_raddr_chan == 0 || reg_raddr_chan > NCH) |->
      (reg_preload == 0 && reg_quad_data == 0 && reg_perd_data == 0
       && reg_qtr1_data == 0 && reg_qtr5_data == 0 && reg_run_data == 0))
      else fail_now($sformatf("read of channel %0d not zero", reg_raddr_chan));

   function automatic logic [1:0] gray_code(input int p);
      case (p)
         0:       return 2'b00;   // {a, b}
         1:       return 2'b10;   // A leads going forward
         2:       return 2'b11;
         default: return 2'b01;
      endcase
   endfunction

   function automatic int rand_gap();
      return `ENC_DEB_CYCLES + 4 + $unsigned($random(seed)) % 24;
   endfunction

   // every task drives on a rising edge and returns on a falling edge
   task automatic sel(input int ch);
      @(posedge sysclk);
      reg_raddr_chan <= 4'(ch);
      @(negedge sysclk);
   endtask

   task automatic put_write(input logic [15:0] addr, input logic [31:0] data, input logic wen);
      @(posedge sysclk);
      reg_waddr <= addr;
      reg_wdata <= data;
      reg_wen   <= wen;
      @(posedge sysclk);   // write edge
      reg_wen   <= 1'b0;
      @(negedge sysclk);
   endtask

   task automatic check_count(input int ch);
      assert (reg_preload == {8'h00, exp_pre[ch]})
         else fail_now($sformatf("ch%0d preload %h exp %h", ch, reg_preload, exp_pre[ch]));
      assert (reg_quad_data == {7'd0, exp_ovf[ch], exp_cnt[ch]})
         else fail_now($sformatf("ch%0d quad %h exp ovf %b cnt %h", ch, reg_quad_data,
                                 exp_ovf[ch], exp_cnt[ch]));
   endtask

   task automatic check_all_chans();
      for (int c = 1; c <= NCH; c++) begin
         sel(c);
         check_count(c);
      end
   endtask

   // periods of the tracked channel against the gap history
   task automatic check_perd(input bit with_q5);
      int sum;
      sum = qtr_hist[0] + qtr_hist[1] + qtr_hist[2] + qtr_hist[3];
      assert (reg_qtr1_data == qtr_hist[0])
         else fail_now($sformatf("qtr1 %0d exp %0d", reg_qtr1_data, qtr_hist[0]));
      assert (reg_perd_data == sum)
         else fail_now($sformatf("perd %0d exp %0d", reg_perd_data, sum));
      if (with_q5) begin
         assert (reg_qtr5_data == qtr_hist[4])
            else fail_now($sformatf("qtr5 %0d exp %0d", reg_qtr5_data, qtr_hist[4]));
      end
   endtask

   task automatic preload(input int ch, input logic [31:0] data);
      sel(ch);
      put_write({`ENC_ADDR_MAIN, 4'h0, 4'(ch), `ENC_OFF_LOAD}, data, 1'b1);
      // register already holds it while the counter lags one cycle
      assert (reg_preload == {8'h00, data[23:0]})
         else fail_now($sformatf("ch%0d preload %h one cycle after write", ch, reg_preload));
      assert (reg_quad_data == {7'd0, exp_ovf[ch], exp_cnt[ch]})
         else fail_now($sformatf("ch%0d count moved early to %h", ch, reg_quad_data));
      exp_pre[ch] = data[23:0];
      @(posedge sysclk);
      @(negedge sysclk);
      exp_cnt[ch] = data[23:0];
      exp_ovf[ch] = 1'b0;   // load clears the wrap flag
      check_count(ch);
   endtask

   // n quadrature edges sp cycles apart
   task automatic move(input int ch, input bit fwd, input int n, input int sp);
      logic [1:0] ab;
      for (int i = 0; i < n; i++) begin
         phase[ch] = fwd ? (phase[ch] + 1) % 4 : (phase[ch] + 3) % 4;
         ab = gray_code(phase[ch]);
         @(posedge sysclk);
         enc_a[ch] <= ab[1];
         enc_b[ch] <= ab[0];
         if (fwd) begin
            exp_ovf[ch] = exp_ovf[ch] | (exp_cnt[ch] == 24'hFFFFFF);
            exp_cnt[ch] = exp_cnt[ch] + 1'b1;
         end else begin
            exp_ovf[ch] = exp_ovf[ch] | (exp_cnt[ch] == 24'h000000);
            exp_cnt[ch] = exp_cnt[ch] - 1'b1;
         end
         if (ch == pch) begin
            qtr_hist.push_front(last_gap);   // gap that this edge closes
            last_gap = sp;
         end
         repeat (sp - 1) @(posedge sysclk);
         @(negedge sysclk);
      end
   endtask

   // pad pulse too short for the filter
   task automatic glitch(input int ch, input bit on_a, input int len);
      @(posedge sysclk);
      if (on_a) enc_a[ch] <= ~enc_a[ch];
      else      enc_b[ch] <= ~enc_b[ch];
      repeat (len) @(posedge sysclk);
      if (on_a) enc_a[ch] <= ~enc_a[ch];
      else      enc_b[ch] <= ~enc_b[ch];
      repeat (LAT + 4) @(posedge sysclk);
      @(negedge sysclk);
   endtask

   initial begin
      int ch;
      int sp1;
      int sp2;
      int len;
      rst            = 1'b1;
      enc_a          = '0;
      enc_b          = '0;
      reg_raddr_chan = 4'h0;
      reg_waddr      = 16'h0000;
      reg_wdata      = 32'h0;
      reg_wen        = 1'b0;
      pch            = 0;
      last_gap       = 0;
      for (int c = 1; c <= NCH; c++) begin
         exp_pre[c] = `ENC_MIDRANGE;
         exp_cnt[c] = `ENC_MIDRANGE;
         exp_ovf[c] = 1'b0;
         phase[c]   = 0;
      end
      repeat (3) @(posedge sysclk);
      rst <= 1'b0;
      @(negedge sysclk);

      // ----------------------------------------
      // reset state and preload path
      // ----------------------------------------
      for (int c = 1; c <= NCH; c++) begin
         sel(c);
         check_count(c);
         assert (reg_perd_data == 0 && reg_qtr1_data == 0 && reg_qtr5_data == 0
                 && reg_run_data == 0)
            else fail_now($sformatf("ch%0d periods not zero after reset", c));
      end
      ch = 1 + $unsigned($random(seed)) % NCH;
      preload(ch, $random(seed));
      check_all_chans();
      put_write({4'h1, 4'h0, 4'(ch), `ENC_OFF_LOAD}, 32'h00123456, 1'b1);          // other space
      put_write({`ENC_ADDR_MAIN, 4'h0, 4'(ch), 4'h5}, 32'h00234567, 1'b1);         // other offset
      put_write({`ENC_ADDR_MAIN, 4'h0, 4'h0, `ENC_OFF_LOAD}, 32'h00345678, 1'b1);  // channel 0
      put_write({`ENC_ADDR_MAIN, 4'h0, 4'(ch), `ENC_OFF_LOAD}, 32'h00456789, 1'b0);
      check_all_chans();

      // counting both ways and wrap
      ch = 1 + $unsigned($random(seed)) % NCH;
      sel(ch);
      move(ch, 1'b1, 7, rand_gap());
      check_count(ch);
      move(ch, 1'b0, 3, rand_gap());
      check_count(ch);
      preload(ch, 32'h00FFFFFE);
      move(ch, 1'b1, 4, rand_gap());
      check_count(ch);
      assert (reg_quad_data == 32'h01000002)
         else fail_now($sformatf("wrap gave %h", reg_quad_data));
      preload(ch, $random(seed));
      check_all_chans();

      // ----------------------------------------
      // periods and glitches on the same channel
      // ----------------------------------------
      ch = 1 + $unsigned($random(seed)) % NCH;
      sel(ch);
      pch = ch;
      qtr_hist.delete();
      last_gap = 0;                 // gap before the first edge is unknown
      sp1 = rand_gap();
      move(ch, 1'b1, 5, sp1);
      check_perd(1'b0);
      assert (reg_run_data >= sp1 - 1 - LAT)
         else fail_now($sformatf("run %0d below %0d", reg_run_data, sp1 - 1 - LAT));
      sp2 = rand_gap();
      while (sp2 == sp1) sp2 = rand_gap();
      // the new spacing walks through every history slot one edge at a time
      for (int i = 0; i < 6; i++) begin
         move(ch, 1'b0, 1, sp2);
         check_perd(1'b1);
      end
      check_count(ch);
      len = `ENC_DEB_CYCLES - 1;    // longest pulse the filter must reject
      glitch(ch, 1'b1, len);
      glitch(ch, 1'b0, len);
      check_count(ch);
      check_perd(1'b1);

      // channels that do not exist
      for (int c = NCH + 1; c <= 16; c++) begin
         sel(c % 16);
         assert (reg_preload == 0 && reg_quad_data == 0 && reg_perd_data == 0
                 && reg_qtr1_data == 0 && reg_qtr5_data == 0 && reg_run_data == 0)
            else fail_now($sformatf("channel %0d reads nonzero", c % 16));
      end
      sel(ch);

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

//--- verilog.f
+incdir+design
design/enc_pkg.sv
design/enc_chan_if.sv
design/enc_debounce.sv
design/enc_quad_counter.sv
design/enc_period_meter.sv
design/enc_channel.sv
design/enc_reg_ctrl.sv
design/enc_top.sv
verif/enc_tb.sv
